// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes handled by this decoder
  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    MISC_MEM = 7'b0001111,
    SYSTEM   = 7'b1110011
  } opcode_t;

  // ADD must stay at zero so a bubble decodes as a plain add
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS2          = 2'd0,
    SRC_B_IMM_OR_SHAMT = 2'd1,
    SRC_B_IMM_U        = 2'd2
  } src_b_sel_t;

  typedef enum logic [1:0] {
    W_ALU   = 2'd0,
    W_PC4   = 2'd1,
    W_IMM_U = 2'd2
  } w_src_t;

  // Branch condition, straight from funct3
  typedef logic [2:0] branch_type_t;

  localparam word_t HALT_WORD = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
  input  decode_pkg::word_t        instr,
  output decode_pkg::opcode_t      opcode,
  output decode_pkg::reg_addr_t    rs1,
  output decode_pkg::reg_addr_t    rs2,
  output decode_pkg::reg_addr_t    rd,
  output decode_pkg::word_t        imm_i_ext,
  output decode_pkg::word_t        imm_uj_ext,
  output decode_pkg::word_t        imm_sb_ext,
  output decode_pkg::word_t        imm_u,
  output decode_pkg::word_t        shamt,
  output logic                     imm_shamt_sel,
  output decode_pkg::src_a_sel_t   src_a_sel,
  output decode_pkg::src_b_sel_t   src_b_sel,
  output decode_pkg::w_src_t       w_src,
  output decode_pkg::alu_op_t      alu_op,
  output logic                     wen,
  output logic                     jump,
  output logic                     j_sel,
  output logic                     branch,
  output decode_pkg::branch_type_t branch_type,
  output logic                     ifence,
  output logic                     halt_instr,
  output logic                     illegal
);

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  decode_pkg::alu_op_t alu_fn;

  // Register fields
  assign opcode = decode_pkg::opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // Immediates, all sign extended from bit 31 except U and shamt
  assign imm_i_ext  = {{20{instr[31]}}, instr[31:20]};
  assign imm_uj_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_sb_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u      = {instr[31:12], 12'b0};
  assign shamt      = {27'b0, instr[24:20]};

  assign branch_type = funct3;

  // Shift immediates take the shamt field instead of the I immediate
  assign imm_shamt_sel = (opcode == decode_pkg::OP_IMM) &&
                         ((funct3 == 3'b001) || (funct3 == 3'b101));

  // ALU function for OP and OP-IMM, SUB only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  alu_fn = (opcode == decode_pkg::OP && funct7[5]) ?
                        decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'b001:  alu_fn = decode_pkg::ALU_SLL;
      3'b010:  alu_fn = decode_pkg::ALU_SLT;
      3'b011:  alu_fn = decode_pkg::ALU_SLTU;
      3'b100:  alu_fn = decode_pkg::ALU_XOR;
      3'b101:  alu_fn = funct7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'b110:  alu_fn = decode_pkg::ALU_OR;
      default: alu_fn = decode_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    src_a_sel  = decode_pkg::SRC_A_RS1;
    src_b_sel  = decode_pkg::SRC_B_RS2;
    w_src      = decode_pkg::W_ALU;
    alu_op     = decode_pkg::ALU_ADD;
    wen        = 1'b0;
    jump       = 1'b0;
    j_sel      = 1'b0;
    branch     = 1'b0;
    ifence     = 1'b0;
    halt_instr = 1'b0;
    illegal    = 1'b0;

    if (instr == decode_pkg::HALT_WORD) begin
      halt_instr = 1'b1;
    end else begin
      case (opcode)
        decode_pkg::OP: begin
          alu_op = alu_fn;
          wen    = 1'b1;
        end
        decode_pkg::OP_IMM: begin
          src_b_sel = decode_pkg::SRC_B_IMM_OR_SHAMT;
          alu_op    = alu_fn;
          wen       = 1'b1;
        end
        decode_pkg::LUI: begin
          src_a_sel = decode_pkg::SRC_A_ZERO;
          src_b_sel = decode_pkg::SRC_B_IMM_U;
          w_src     = decode_pkg::W_IMM_U;
          wen       = 1'b1;
        end
        decode_pkg::AUIPC: begin
          src_a_sel = decode_pkg::SRC_A_PC;
          src_b_sel = decode_pkg::SRC_B_IMM_U;
          wen       = 1'b1;
        end
        decode_pkg::JAL: begin
          w_src = decode_pkg::W_PC4;
          wen   = 1'b1;
          jump  = 1'b1;
          j_sel = 1'b1;
        end
        decode_pkg::JALR: begin
          w_src = decode_pkg::W_PC4;
          wen   = 1'b1;
          jump  = 1'b1;
        end
        decode_pkg::BRANCH: begin
          // Compare rs1 against rs2 in the ALU
          alu_op = decode_pkg::ALU_SUB;
          branch = 1'b1;
        end
        decode_pkg::MISC_MEM: begin
          // Plain FENCE is a no-op on this in-order core
          ifence = (funct3 == 3'b001);
        end
        decode_pkg::SYSTEM: begin
        end
        default: begin
          illegal = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
`default_nettype none

module operand_select (
  input  decode_pkg::src_a_sel_t src_a_sel,
  input  decode_pkg::src_b_sel_t src_b_sel,
  input  decode_pkg::w_src_t     w_src,
  input  logic                   j_sel,
  input  logic                   imm_shamt_sel,
  input  decode_pkg::word_t      rs1_data,
  input  decode_pkg::word_t      rs2_data,
  input  decode_pkg::word_t      pc,
  input  decode_pkg::word_t      pc4,
  input  decode_pkg::word_t      imm_i_ext,
  input  decode_pkg::word_t      imm_uj_ext,
  input  decode_pkg::word_t      imm_u,
  input  decode_pkg::word_t      shamt,
  output decode_pkg::word_t      port_a,
  output decode_pkg::word_t      port_b,
  output decode_pkg::word_t      wdata,
  output decode_pkg::word_t      j_base,
  output decode_pkg::word_t      j_offset
);

  decode_pkg::word_t imm_or_shamt;

  assign imm_or_shamt = imm_shamt_sel ? shamt : imm_i_ext;

  always_comb begin
    case (src_a_sel)
      decode_pkg::SRC_A_RS1: port_a = rs1_data;
      decode_pkg::SRC_A_PC:  port_a = pc;
      default:               port_a = '0;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      decode_pkg::SRC_B_RS2:          port_b = rs2_data;
      decode_pkg::SRC_B_IMM_OR_SHAMT: port_b = imm_or_shamt;
      decode_pkg::SRC_B_IMM_U:        port_b = imm_u;
      default:                        port_b = '0;
    endcase
  end

  // ALU results are picked up in execute, only the side values go here
  always_comb begin
    case (w_src)
      decode_pkg::W_PC4:   wdata = pc4;
      decode_pkg::W_IMM_U: wdata = imm_u;
      default:             wdata = '0;
    endcase
  end

  // JAL is pc relative, JALR is register relative
  always_comb begin
    if (j_sel) begin
      j_base   = pc;
      j_offset = imm_uj_ext;
    end else begin
      j_base   = rs1_data;
      j_offset = imm_i_ext;
    end
  end

endmodule

`default_nettype wire

// ==== source/fence_tracker.sv ====
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic ifence,
  input  logic pc_en,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic iflushed,
  output logic dflushed
);

  logic ifence_prev;
  logic fence_pulse;

  // Previous fence level, only moves when the pipeline advances
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_prev <= 1'b0;
    end else if (pc_en) begin
      ifence_prev <= ifence;
    end
  end

  // Rising edge, so a run of FENCE.I flushes once
  assign fence_pulse  = ifence && !ifence_prev;
  assign icache_flush = fence_pulse;
  assign dcache_flush = fence_pulse;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
    end else if (fence_pulse) begin
      iflushed <= 1'b0;
    end else if (iflush_done && pc_en) begin
      iflushed <= 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dflushed <= 1'b1;
    end else if (fence_pulse) begin
      dflushed <= 1'b0;
    end else if (dflush_done && pc_en) begin
      dflushed <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/id_ex_latch.sv ====
`default_nettype none

module id_ex_latch (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     id_ex_flush,
  input  logic                     stall_fetch_decode,
  input  logic                     stall_ex,
  input  logic                     halt,
  input  decode_pkg::word_t        pc,
  input  decode_pkg::word_t        pc4,
  input  decode_pkg::word_t        port_a,
  input  decode_pkg::word_t        port_b,
  input  decode_pkg::word_t        wdata,
  input  decode_pkg::word_t        j_base,
  input  decode_pkg::word_t        j_offset,
  input  decode_pkg::alu_op_t      alu_op,
  input  decode_pkg::w_src_t       w_src,
  input  logic                     wen,
  input  decode_pkg::reg_addr_t    rd,
  input  logic                     jump,
  input  logic                     j_sel,
  input  logic                     branch,
  input  decode_pkg::branch_type_t branch_type,
  input  logic                     halt_instr,
  input  logic                     ifence,
  input  logic                     illegal,
  output decode_pkg::word_t        ex_pc,
  output decode_pkg::word_t        ex_pc4,
  output decode_pkg::word_t        ex_port_a,
  output decode_pkg::word_t        ex_port_b,
  output decode_pkg::word_t        ex_wdata,
  output decode_pkg::word_t        ex_j_base,
  output decode_pkg::word_t        ex_j_offset,
  output decode_pkg::alu_op_t      ex_alu_op,
  output decode_pkg::w_src_t       ex_w_src,
  output logic                     ex_wen,
  output decode_pkg::reg_addr_t    ex_rd,
  output logic                     ex_jump,
  output logic                     ex_j_sel,
  output logic                     ex_branch,
  output decode_pkg::branch_type_t ex_branch_type,
  output logic                     ex_halt,
  output logic                     ex_ifence,
  output logic                     ex_illegal
);

  logic bubble;

  // Stall upstream with execute free means nothing valid moves on
  assign bubble = id_ex_flush || halt || (stall_fetch_decode && !stall_ex);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST || bubble) begin
      ex_pc          <= '0;
      ex_pc4         <= '0;
      ex_port_a      <= '0;
      ex_port_b      <= '0;
      ex_wdata       <= '0;
      ex_j_base      <= '0;
      ex_j_offset    <= '0;
      ex_alu_op      <= decode_pkg::ALU_ADD;
      ex_w_src       <= decode_pkg::W_ALU;
      ex_wen         <= 1'b0;
      ex_rd          <= '0;
      ex_jump        <= 1'b0;
      ex_j_sel       <= 1'b0;
      ex_branch      <= 1'b0;
      ex_branch_type <= '0;
      ex_ifence      <= 1'b0;
      ex_illegal     <= 1'b0;
    end else if (!stall_ex) begin
      ex_pc          <= pc;
      ex_pc4         <= pc4;
      ex_port_a      <= port_a;
      ex_port_b      <= port_b;
      ex_wdata       <= wdata;
      ex_j_base      <= j_base;
      ex_j_offset    <= j_offset;
      ex_alu_op      <= alu_op;
      ex_w_src       <= w_src;
      ex_wen         <= wen;
      ex_rd          <= rd;
      ex_jump        <= jump;
      ex_j_sel       <= j_sel;
      ex_branch      <= branch;
      ex_branch_type <= branch_type;
      ex_ifence      <= ifence;
      ex_illegal     <= illegal;
    end
  end

  // Halt only reaches execute on a clean advance, never held through a stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_halt <= 1'b0;
    end else if (bubble || stall_ex || stall_fetch_decode) begin
      ex_halt <= 1'b0;
    end else begin
      ex_halt <= halt_instr;
    end
  end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  decode_pkg::word_t        instr,
  input  decode_pkg::word_t        pc,
  input  decode_pkg::word_t        pc4,
  input  decode_pkg::word_t        rs1_data,
  input  decode_pkg::word_t        rs2_data,
  input  logic                     pc_en,
  input  logic                     stall_ex,
  input  logic                     stall_fetch_decode,
  input  logic                     id_ex_flush,
  input  logic                     halt,
  input  logic                     iflush_done,
  input  logic                     dflush_done,
  output decode_pkg::reg_addr_t    rs1,
  output decode_pkg::reg_addr_t    rs2,
  output logic                     icache_flush,
  output logic                     dcache_flush,
  output logic                     iflushed,
  output logic                     dflushed,
  output decode_pkg::word_t        ex_pc,
  output decode_pkg::word_t        ex_pc4,
  output decode_pkg::word_t        ex_port_a,
  output decode_pkg::word_t        ex_port_b,
  output decode_pkg::word_t        ex_wdata,
  output decode_pkg::word_t        ex_j_base,
  output decode_pkg::word_t        ex_j_offset,
  output decode_pkg::alu_op_t      ex_alu_op,
  output decode_pkg::w_src_t       ex_w_src,
  output logic                     ex_wen,
  output decode_pkg::reg_addr_t    ex_rd,
  output logic                     ex_jump,
  output logic                     ex_j_sel,
  output logic                     ex_branch,
  output decode_pkg::branch_type_t ex_branch_type,
  output logic                     ex_halt,
  output logic                     ex_ifence,
  output logic                     ex_illegal
);

  decode_pkg::reg_addr_t    rd;
  decode_pkg::word_t        imm_i_ext;
  decode_pkg::word_t        imm_uj_ext;
  decode_pkg::word_t        imm_u;
  decode_pkg::word_t        shamt;
  logic                     imm_shamt_sel;
  decode_pkg::src_a_sel_t   src_a_sel;
  decode_pkg::src_b_sel_t   src_b_sel;
  decode_pkg::w_src_t       w_src;
  decode_pkg::alu_op_t      alu_op;
  logic                     wen;
  logic                     jump;
  logic                     j_sel;
  logic                     branch;
  decode_pkg::branch_type_t branch_type;
  logic                     ifence;
  logic                     halt_instr;
  logic                     illegal;
  decode_pkg::word_t        port_a;
  decode_pkg::word_t        port_b;
  decode_pkg::word_t        wdata;
  decode_pkg::word_t        j_base;
  decode_pkg::word_t        j_offset;

  // Opcode and branch offset are not consumed past decode in this core
  instr_decoder decoder_i (
    .instr(instr), .opcode(), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm_i_ext(imm_i_ext), .imm_uj_ext(imm_uj_ext), .imm_sb_ext(), .imm_u(imm_u),
    .shamt(shamt), .imm_shamt_sel(imm_shamt_sel),
    .src_a_sel(src_a_sel), .src_b_sel(src_b_sel), .w_src(w_src), .alu_op(alu_op),
    .wen(wen), .jump(jump), .j_sel(j_sel), .branch(branch), .branch_type(branch_type),
    .ifence(ifence), .halt_instr(halt_instr), .illegal(illegal)
  );

  operand_select operand_select_i (
    .src_a_sel(src_a_sel), .src_b_sel(src_b_sel), .w_src(w_src),
    .j_sel(j_sel), .imm_shamt_sel(imm_shamt_sel),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .pc4(pc4),
    .imm_i_ext(imm_i_ext), .imm_uj_ext(imm_uj_ext), .imm_u(imm_u), .shamt(shamt),
    .port_a(port_a), .port_b(port_b), .wdata(wdata),
    .j_base(j_base), .j_offset(j_offset)
  );

  fence_tracker fence_tracker_i (
    .CLK(CLK), .nRST(nRST), .ifence(ifence), .pc_en(pc_en),
    .iflush_done(iflush_done), .dflush_done(dflush_done),
    .icache_flush(icache_flush), .dcache_flush(dcache_flush),
    .iflushed(iflushed), .dflushed(dflushed)
  );

  id_ex_latch id_ex_latch_i (
    .CLK(CLK), .nRST(nRST),
    .id_ex_flush(id_ex_flush), .stall_fetch_decode(stall_fetch_decode),
    .stall_ex(stall_ex), .halt(halt),
    .pc(pc), .pc4(pc4), .port_a(port_a), .port_b(port_b), .wdata(wdata),
    .j_base(j_base), .j_offset(j_offset), .alu_op(alu_op), .w_src(w_src),
    .wen(wen), .rd(rd), .jump(jump), .j_sel(j_sel), .branch(branch),
    .branch_type(branch_type), .halt_instr(halt_instr), .ifence(ifence),
    .illegal(illegal),
    .ex_pc(ex_pc), .ex_pc4(ex_pc4), .ex_port_a(ex_port_a), .ex_port_b(ex_port_b),
    .ex_wdata(ex_wdata), .ex_j_base(ex_j_base), .ex_j_offset(ex_j_offset),
    .ex_alu_op(ex_alu_op), .ex_w_src(ex_w_src), .ex_wen(ex_wen), .ex_rd(ex_rd),
    .ex_jump(ex_jump), .ex_j_sel(ex_j_sel), .ex_branch(ex_branch),
    .ex_branch_type(ex_branch_type), .ex_halt(ex_halt), .ex_ifence(ex_ifence),
    .ex_illegal(ex_illegal)
  );

endmodule

`default_nettype wire

// ==== sim/tb_decode_stage.sv ====
`default_nettype none

module tb_decode_stage;

  // Expected contents of the decode/execute latch
  typedef struct packed {
    logic [31:0] pc, pc4, port_a, port_b, wdata, j_base, j_offset;
    logic [3:0]  alu_op;
    logic [1:0]  w_src;
    logic        wen;
    logic [4:0]  rd;
    logic        jump, j_sel, branch;
    logic [2:0]  branch_type;
    logic        halt, ifence, illegal;
  } ex_t;

  localparam logic [31:0] NOP     = 32'h0000_0013;
  localparam logic [31:0] FENCE_I = 32'h0000_100F;

  logic CLK = 1'b0;
  logic nRST;
  decode_pkg::word_t instr, pc, pc4, rs1_data, rs2_data;
  logic pc_en, stall_ex, stall_fetch_decode, id_ex_flush, halt, iflush_done, dflush_done;
  decode_pkg::reg_addr_t rs1, rs2, ex_rd;
  logic icache_flush, dcache_flush, iflushed, dflushed;
  decode_pkg::word_t ex_pc, ex_pc4, ex_port_a, ex_port_b, ex_wdata, ex_j_base, ex_j_offset;
  decode_pkg::alu_op_t ex_alu_op;
  decode_pkg::w_src_t ex_w_src;
  decode_pkg::branch_type_t ex_branch_type;
  logic ex_wen, ex_jump, ex_j_sel, ex_branch, ex_halt, ex_ifence, ex_illegal;

  // Reference model state
  ex_t  exp_ex;
  logic fence_prev_m, exp_iflushed, exp_dflushed;
  int   errors, checks, pulses;
  logic [31:0] rand_state;

  // Mostly legal opcodes plus LOAD, STORE and zero which this stage rejects
  logic [6:0] op_table [16] = '{7'h33, 7'h33, 7'h13, 7'h13, 7'h37, 7'h17, 7'h6F, 7'h67,
                                7'h63, 7'h0F, 7'h0F, 7'h0F, 7'h73, 7'h03, 7'h23, 7'h00};

  decode_stage decode_stage_i (.*);

  initial begin
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rand_state = xorshift32(rand_state);
    return rand_state;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] b, a,
                                         input logic [2:0] f3, input logic [4:0] d,
                                         input logic [6:0] op);
    return {f7, b, a, f3, d, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] a,
                                         input logic [2:0] f3, input logic [4:0] d,
                                         input logic [6:0] op);
    return {imm, a, f3, d, op};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] d,
                                         input logic [6:0] op);
    return {imm, d, op};
  endfunction

  // JAL scatters its offset as imm[20|10:1|11|19:12]
  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] d);
    return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'h6F};
  endfunction

  // What the latch should load for one instruction under the RV32I field rules
  function automatic ex_t reference_decode(input logic [31:0] w, pc_v, pc4_v, a_v, b_v);
    ex_t r;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [31:0] imm_i, imm_j, imm_u;
    logic [3:0]  fn;
    op    = w[6:0];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'h000};
    case (f3)
      3'd0:    fn = (op == 7'h33 && w[30]) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'd1:    fn = decode_pkg::ALU_SLL;
      3'd2:    fn = decode_pkg::ALU_SLT;
      3'd3:    fn = decode_pkg::ALU_SLTU;
      3'd4:    fn = decode_pkg::ALU_XOR;
      3'd5:    fn = w[30] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'd6:    fn = decode_pkg::ALU_OR;
      default: fn = decode_pkg::ALU_AND;
    endcase
    r = '0;
    r.pc          = pc_v;
    r.pc4         = pc4_v;
    r.port_a      = a_v;
    r.port_b      = b_v;
    r.j_base      = a_v;
    r.j_offset    = imm_i;
    r.rd          = w[11:7];
    r.branch_type = f3;
    if (w == 32'hFFFF_FFFF) begin
      r.halt = 1'b1;
    end else begin
      case (op)
        7'h33: {r.alu_op, r.wen} = {fn, 1'b1};
        7'h13: begin
          r.port_b = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, w[24:20]} : imm_i;
          {r.alu_op, r.wen} = {fn, 1'b1};
        end
        7'h37: {r.port_a, r.port_b, r.w_src, r.wdata, r.wen} = {32'h0, imm_u, 2'd2, imm_u, 1'b1};
        7'h17: {r.port_a, r.port_b, r.wen} = {pc_v, imm_u, 1'b1};
        7'h6F: begin
          {r.w_src, r.wdata, r.wen, r.jump, r.j_sel} = {2'd1, pc4_v, 3'b111};
          {r.j_base, r.j_offset} = {pc_v, imm_j};
        end
        7'h67: {r.w_src, r.wdata, r.wen, r.jump} = {2'd1, pc4_v, 2'b11};
        7'h63: {r.alu_op, r.branch} = {4'(decode_pkg::ALU_SUB), 1'b1};
        7'h0F: r.ifence = (f3 == 3'd1);
        7'h73: r.illegal = 1'b0;
        default: r.illegal = 1'b1;
      endcase
    end
    return r;
  endfunction

  task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task verify_latch(input ex_t e);
    compare("ex_pc", ex_pc, e.pc);
    compare("ex_pc4", ex_pc4, e.pc4);
    compare("ex_port_a", ex_port_a, e.port_a);
    compare("ex_port_b", ex_port_b, e.port_b);
    compare("ex_wdata", ex_wdata, e.wdata);
    compare("ex_j_base", ex_j_base, e.j_base);
    compare("ex_j_offset", ex_j_offset, e.j_offset);
    compare("ex_alu_op", 32'(ex_alu_op), 32'(e.alu_op));
    compare("ex_w_src", 32'(ex_w_src), 32'(e.w_src));
    compare("ex_wen", 32'(ex_wen), 32'(e.wen));
    compare("ex_rd", 32'(ex_rd), 32'(e.rd));
    compare("ex_jump", 32'(ex_jump), 32'(e.jump));
    compare("ex_j_sel", 32'(ex_j_sel), 32'(e.j_sel));
    compare("ex_branch", 32'(ex_branch), 32'(e.branch));
    compare("ex_branch_type", 32'(ex_branch_type), 32'(e.branch_type));
    compare("ex_halt", 32'(ex_halt), 32'(e.halt));
    compare("ex_ifence", 32'(ex_ifence), 32'(e.ifence));
    compare("ex_illegal", 32'(ex_illegal), 32'(e.illegal));
    compare("iflushed", 32'(iflushed), 32'(exp_iflushed));
    compare("dflushed", 32'(dflushed), 32'(exp_dflushed));
  endtask

  task present(input logic [31:0] w);
    instr    = w;
    rs1_data = next_rand();
    rs2_data = next_rand();
    pc       = next_rand() & 32'hFFFF_FFFC;
    pc4      = pc + 32'd4;
  endtask

  // One clock of checking the decode side, predicting the latch and checking it
  task advance();
    ex_t  dec, nxt;
    logic pulse, bubble;
    #1;
    dec   = reference_decode(instr, pc, pc4, rs1_data, rs2_data);
    pulse = dec.ifence && !fence_prev_m;
    compare("rs1", 32'(rs1), 32'(instr[19:15]));
    compare("rs2", 32'(rs2), 32'(instr[24:20]));
    compare("icache_flush", 32'(icache_flush), 32'(pulse));
    compare("dcache_flush", 32'(dcache_flush), 32'(pulse));
    if (icache_flush) pulses++;
    bubble = id_ex_flush || halt || (stall_fetch_decode && !stall_ex);
    nxt = bubble ? '0 : (stall_ex ? exp_ex : dec);
    if (stall_ex) nxt.halt = 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    exp_ex = nxt;
    exp_iflushed = pulse ? 1'b0 : (exp_iflushed || (iflush_done && pc_en));
    exp_dflushed = pulse ? 1'b0 : (exp_dflushed || (dflush_done && pc_en));
    if (pc_en) fence_prev_m = dec.ifence;
    verify_latch(exp_ex);
  endtask

  task wait_flushed(input logic data_side, input int limit);
    int n;
    n = 0;
    while ((data_side ? dflushed : iflushed) !== 1'b1 && n < limit) begin
      advance();
      n++;
    end
    if ((data_side ? dflushed : iflushed) !== 1'b1) begin
      errors++;
      $display("Timed out waiting for the %s flush to complete", data_side ? "data" : "instr");
    end
  endtask

  initial begin
    int i;
    logic [31:0] r, w;
    rand_state = 32'd35;
    {errors, checks, pulses} = '0;
    {nRST, pc_en, stall_ex, stall_fetch_decode, id_ex_flush, halt} = 6'b010000;
    {iflush_done, dflush_done} = 2'b00;
    {instr, pc, pc4, rs1_data, rs2_data} = {NOP, 32'h0, 32'h4, 32'h0, 32'h0};
    {exp_ex, fence_prev_m, exp_iflushed, exp_dflushed} = {ex_t'(0), 3'b011};
    repeat (3) @(negedge CLK);
    verify_latch(exp_ex);
    compare("icache_flush", 32'(icache_flush), 32'h0);
    compare("dcache_flush", 32'(dcache_flush), 32'h0);
    nRST = 1'b1;

    // ADDI, SLLI and register ALU ops
    for (i = 0; i < 40; i++) begin
      r = next_rand();
      case (r[9:8])
        2'd0:    present(i_type(r[31:20], r[19:15], 3'd0, r[14:10], 7'h13));
        2'd1:    present(i_type({7'h00, r[24:20]}, r[19:15], 3'd1, r[14:10], 7'h13));
        default: present(r_type({1'b0, r[30] & (r[2:0] == 3'd0 || r[2:0] == 3'd5), 5'b0},
                                r[24:20], r[19:15], r[2:0], r[14:10], 7'h33));
      endcase
      advance();
    end

    // Upper immediates and jumps
    for (i = 0; i < 12; i++) begin
      r = next_rand();
      case (i % 4)
        0:       present(u_type(r[31:12], r[11:7], 7'h37));
        1:       present(u_type(r[31:12], r[11:7], 7'h17));
        2:       present(j_type(r[20:0], r[11:7]));
        default: present(i_type(r[31:20], r[19:15], 3'd0, r[11:7], 7'h67));
      endcase
      advance();
    end

    // Hold under stall with a halt word in it and then each bubble cause
    present(i_type(12'h7FF, 5'd3, 3'd0, 5'd9, 7'h13));
    advance();
    stall_ex = 1'b1;
    repeat (3) begin
      present(next_rand());
      advance();
    end
    present(32'hFFFF_FFFF);
    advance();
    stall_fetch_decode = 1'b1;
    advance();
    stall_ex = 1'b0;
    advance();
    stall_fetch_decode = 1'b0;
    present(NOP);
    advance();
    id_ex_flush = 1'b1;
    advance();
    {id_ex_flush, halt} = 2'b01;
    advance();
    halt = 1'b0;

    // A held FENCE.I flushes once and the done flags come back after
    pulses = 0;
    present(FENCE_I);
    repeat (4) advance();
    compare("flush pulse count", 32'(pulses), 32'd1);
    present(NOP);
    {pc_en, iflush_done} = 2'b01;
    advance();
    pc_en = 1'b1;
    wait_flushed(1'b0, 5);
    {iflush_done, dflush_done} = 2'b01;
    wait_flushed(1'b1, 5);
    dflush_done = 1'b0;

    // Rejected opcode, halt word and a branch
    r = next_rand();
    present({r[31:7], 7'h03});
    advance();
    present(32'hFFFF_FFFF);
    advance();
    r = next_rand();
    present({r[31:7], 7'h63});
    advance();

    // Random traffic with random hazard controls
    for (i = 0; i < 60; i++) begin
      r = next_rand();
      w = next_rand();
      w[6:0] = op_table[r[19:16]];
      if (w[6:0] == 7'h0F && r[20]) w[14:12] = 3'b001;
      if (r[19:16] == 4'hF && r[21]) w = 32'hFFFF_FFFF;
      present(w);
      {stall_ex, stall_fetch_decode} = {r[0] & r[1], r[2] & r[3]};
      {id_ex_flush, halt} = {r[4] & r[5] & r[6], r[7] & r[8] & r[9]};
      {pc_en, iflush_done, dflush_done} = {r[11] | r[12], r[13], r[14]};
      advance();
    end

    $display("Errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/decode_pkg.sv
source/instr_decoder.sv
source/operand_select.sv
source/fence_tracker.sv
source/id_ex_latch.sv
source/decode_stage.sv
sim/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module tb_decode_stage -o tb_decode_stage &&
out=$(./obj_dir/tb_decode_stage) &&
echo "$out" &&
echo "$out" | grep -q "All tests passed" ||
{ echo "Simulation did not pass"; exit 1; }
